// File: core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath width, one RV64 register
`define XLEN 64

// architectural register file, x0 included
`define REG_COUNT 32
`define REG_ADDR_W 5

// base ISA instruction word
`define INSTR_W 32

`endif

// File: core_pkg.sv
`default_nettype none

`include "core_params.svh"

package core_pkg;

    // major opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // alu function, picked in decode and carried to execute
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // ----------------------------------------
    // instruction field positions
    // ----------------------------------------
    localparam int OPC_LSB   = 0;
    localparam int RD_LSB    = 7;
    localparam int F3_LSB    = 12;
    localparam int RS1_LSB   = 15;
    localparam int RS2_LSB   = 20;
    localparam int F7_LSB    = 25;
    localparam int IMM_I_LSB = 20;
    // bit 30 tells sub from add and sra from srl
    localparam int ALT_BIT   = 30;

endpackage

`default_nettype wire

// File: pipe_ifs.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

// decode to execute, one decoded operation
interface dec_ex_if;
    import core_pkg::*;

    logic                   valid;
    logic                   ready;
    alu_op_e                op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       opa;
    logic [`XLEN-1:0]       opb;
    logic                   wr_en;
    logic                   illegal;

    modport src (output valid, op, rd, opa, opb, wr_en, illegal, input ready);
    modport dst (input valid, op, rd, opa, opb, wr_en, illegal, output ready);
endinterface

// execute to result, one computed value
interface ex_res_if;
    logic                   valid;
    logic                   ready;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       result;
    logic                   wr_en;
    logic                   illegal;

    modport src (output valid, rd, result, wr_en, illegal, input ready);
    modport dst (input valid, rd, result, wr_en, illegal, output ready);
    // decode looks at the execute output for forwarding
    modport peek (input valid, rd, wr_en, result);
endinterface

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module reg_file (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    we,
    input  wire [`REG_ADDR_W-1:0]  waddr,
    input  wire [`XLEN-1:0]        wdata,
    input  wire [`REG_ADDR_W-1:0]  raddr_a,
    input  wire [`REG_ADDR_W-1:0]  raddr_b,
    output wire [`XLEN-1:0]        rdata_a,
    output wire [`XLEN-1:0]        rdata_b
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write is seen by the reader
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (we && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

`default_nettype wire

// File: instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module instr_decode (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    in_valid,
    output logic                   in_ready,
    input  wire [`INSTR_W-1:0]     in_instr,
    output logic [`REG_ADDR_W-1:0] raddr_a,
    output logic [`REG_ADDR_W-1:0] raddr_b,
    input  wire [`XLEN-1:0]        rdata_a,
    input  wire [`XLEN-1:0]        rdata_b,
    dec_ex_if.src                  dx,
    ex_res_if.peek                 ex_peek,
    input  wire                    res_wr_en,
    input  wire [`REG_ADDR_W-1:0]  res_rd,
    input  wire [`XLEN-1:0]        res_data,
    input  wire                    res_valid
);
    import core_pkg::*;

    opcode_e                opcode;
    logic [`REG_ADDR_W-1:0] rd, rs1, rs2;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`XLEN-1:0]       imm_i;
    alu_op_e                op_sel;
    logic                   illegal, uses_rs2, hazard, accept;
    logic                   ex_hit_ok, res_hit_ok;
    logic [`XLEN-1:0]       fwd_a, fwd_b;

    // funct3 to alu op, alt comes from bit 30
    function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // priority: x0, execute output, result stage, register file
    function automatic logic [`XLEN-1:0] pick(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       rf_data,
        input logic                   ex_ok,
        input logic [`REG_ADDR_W-1:0] ex_rd,
        input logic [`XLEN-1:0]       ex_data,
        input logic                   res_ok,
        input logic [`REG_ADDR_W-1:0] rs_rd,
        input logic [`XLEN-1:0]       rs_data
    );
        if (rs == '0) return '0;
        if (ex_ok && ex_rd == rs) return ex_data;
        if (res_ok && rs_rd == rs) return rs_data;
        return rf_data;
    endfunction

    // ----------------------------------------
    // field split
    // ----------------------------------------
    assign opcode = opcode_e'(in_instr[OPC_LSB +: 7]);
    assign rd     = in_instr[RD_LSB +: `REG_ADDR_W];
    assign funct3 = in_instr[F3_LSB +: 3];
    assign rs1    = in_instr[RS1_LSB +: `REG_ADDR_W];
    assign rs2    = in_instr[RS2_LSB +: `REG_ADDR_W];
    assign funct7 = in_instr[F7_LSB +: 7];
    assign imm_i  = {{(`XLEN-12){in_instr[`INSTR_W-1]}}, in_instr[IMM_I_LSB +: 12]};

    assign raddr_a = rs1;
    assign raddr_b = rs2;

    always_comb begin
        op_sel   = ALU_ADD;
        illegal  = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                uses_rs2 = 1'b1;
                op_sel   = f3_to_op(funct3, in_instr[ALT_BIT]);
                // only 0100000 with add/sub and srl/sra is defined besides zero
                if (funct7 != 7'b0000000 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
                    illegal = 1'b1;
            end
            OPC_OP_IMM: begin
                // no subi, so alt only matters for shifts
                op_sel = f3_to_op(funct3, funct3 == 3'b101 && in_instr[ALT_BIT]);
            end
            default: illegal = 1'b1;
        endcase
    end

    // ----------------------------------------
    // operands and stall
    // ----------------------------------------
    assign ex_hit_ok  = ex_peek.valid && ex_peek.wr_en;
    assign res_hit_ok = res_valid && res_wr_en;

    always_comb begin
        fwd_a = pick(rs1, rdata_a, ex_hit_ok, ex_peek.rd, ex_peek.result,
                     res_hit_ok, res_rd, res_data);
        fwd_b = pick(rs2, rdata_b, ex_hit_ok, ex_peek.rd, ex_peek.result,
                     res_hit_ok, res_rd, res_data);
    end

    // the entry still in our own register has no result yet, wait for it
    assign hazard = dx.valid && dx.wr_en &&
                    (rs1 == dx.rd || (uses_rs2 && rs2 == dx.rd));

    assign in_ready = !hazard && (!dx.valid || dx.ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset)
            dx.valid <= 1'b0;
        else if (accept)
            dx.valid <= 1'b1;
        else if (dx.ready)
            dx.valid <= 1'b0;
    end

    // payload, loaded only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            dx.op      <= op_sel;
            dx.rd      <= rd;
            dx.opa     <= fwd_a;
            dx.opb     <= uses_rs2 ? fwd_b : imm_i;
            // writes to x0 are dropped but stay legal
            dx.wr_en   <= !illegal && rd != '0;
            dx.illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

// File: alu_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module alu_execute (
    input  wire     clk,
    input  wire     reset,
    dec_ex_if.dst   dx,
    ex_res_if.src   xr
);
    import core_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s, lt_u;
    logic [`XLEN-1:0]   alu_out;
    logic               take;

    // ----------------------------------------
    // alu
    // ----------------------------------------
    // rv64 shifts use the low 6 bits of opb
    assign shamt = dx.opb[SHAMT_W-1:0];
    assign lt_s  = $signed(dx.opa) < $signed(dx.opb);
    assign lt_u  = dx.opa < dx.opb;

    always_comb begin
        case (dx.op)
            ALU_ADD:  alu_out = dx.opa + dx.opb;
            ALU_SUB:  alu_out = dx.opa - dx.opb;
            ALU_SLL:  alu_out = dx.opa << shamt;
            ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  alu_out = dx.opa ^ dx.opb;
            ALU_SRL:  alu_out = dx.opa >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  alu_out = $signed(dx.opa) >>> shamt;
            ALU_OR:   alu_out = dx.opa | dx.opb;
            ALU_AND:  alu_out = dx.opa & dx.opb;
            default:  alu_out = '0;
        endcase
    end

    // ----------------------------------------
    // execute output register
    // ----------------------------------------
    // free slot, or the held result leaves this cycle
    assign dx.ready = !xr.valid || xr.ready;
    assign take     = dx.valid && dx.ready;

    always_ff @(posedge clk) begin
        if (reset)
            xr.valid <= 1'b0;
        else if (take)
            xr.valid <= 1'b1;
        else if (xr.ready)
            xr.valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            xr.rd      <= dx.rd;
            xr.result  <= alu_out;
            xr.wr_en   <= dx.wr_en;
            xr.illegal <= dx.illegal;
        end
    end

endmodule

`default_nettype wire

// File: result_writeback.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module result_writeback (
    input  wire                    clk,
    input  wire                    reset,
    ex_res_if.dst                  xr,
    output logic                   wb_valid,
    input  wire                    wb_ready,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data,
    output logic                   wb_illegal,
    output logic                   rf_we,
    output logic [`REG_ADDR_W-1:0] rf_waddr,
    output logic [`XLEN-1:0]       rf_wdata,
    output logic                   res_valid,
    output logic                   res_wr_en,
    output logic [`REG_ADDR_W-1:0] res_rd
);

    logic held_wr_en;
    logic take;

    assign xr.ready = !wb_valid || wb_ready;
    assign take     = xr.valid && xr.ready;

    always_ff @(posedge clk) begin
        if (reset)
            wb_valid <= 1'b0;
        else if (take)
            wb_valid <= 1'b1;
        else if (wb_ready)
            wb_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wb_rd      <= xr.rd;
            wb_data    <= xr.result;
            wb_illegal <= xr.illegal;
            held_wr_en <= xr.wr_en;
        end
    end

    // commit to the register file as the result retires
    assign rf_we    = wb_valid && wb_ready && held_wr_en;
    assign rf_waddr = wb_rd;
    assign rf_wdata = wb_data;

    // held entry, seen by decode for forwarding
    assign res_valid = wb_valid;
    assign res_wr_en = held_wr_en;
    assign res_rd    = wb_rd;

endmodule

`default_nettype wire

// File: alu_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module alu_pipe_top (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    in_valid,
    output wire                    in_ready,
    input  wire [`INSTR_W-1:0]     in_instr,
    output wire                    wb_valid,
    input  wire                    wb_ready,
    output wire [`REG_ADDR_W-1:0]  wb_rd,
    output wire [`XLEN-1:0]        wb_data,
    output wire                    wb_illegal
);

    // ----------------------------------------
    // stage links
    // ----------------------------------------
    dec_ex_if dx_bus ();
    ex_res_if xr_bus ();

    wire                   rf_we;
    wire [`REG_ADDR_W-1:0] rf_waddr, raddr_a, raddr_b, res_rd;
    wire [`XLEN-1:0]       rf_wdata, rdata_a, rdata_b;
    wire                   res_valid, res_wr_en;

    reg_file u_rf (
        .clk(clk), .reset(reset),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr_a(raddr_a), .raddr_b(raddr_b),
        .rdata_a(rdata_a), .rdata_b(rdata_b)
    );

    // result data doubles as the forwarding value from the last stage
    instr_decode u_dec (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
        .raddr_a(raddr_a), .raddr_b(raddr_b),
        .rdata_a(rdata_a), .rdata_b(rdata_b),
        .dx(dx_bus), .ex_peek(xr_bus),
        .res_wr_en(res_wr_en), .res_rd(res_rd),
        .res_data(wb_data), .res_valid(res_valid)
    );

    alu_execute u_ex (.clk(clk), .reset(reset), .dx(dx_bus), .xr(xr_bus));

    result_writeback u_wb (
        .clk(clk), .reset(reset), .xr(xr_bus),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_rd(wb_rd),
        .wb_data(wb_data), .wb_illegal(wb_illegal),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .res_valid(res_valid), .res_wr_en(res_wr_en), .res_rd(res_rd)
    );

endmodule

`default_nettype wire

// File: tb_alu_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module tb_alu_pipe;
    import core_pkg::*;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   in_valid;
    logic                   in_ready;
    logic [`INSTR_W-1:0]    in_instr;
    logic                   wb_valid;
    logic                   wb_ready = 1'b1;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;
    logic                   wb_illegal;

    // one table row per instruction at the same index in every queue
    string               names[$];
    logic [`INSTR_W-1:0] instrs[$];
    int                  exp_rd[$];
    logic [`XLEN-1:0]    exp_data[$];
    int                  exp_ill[$];

    integer seed = 27925;
    int     cycle_count = 0;
    int     timeout_limit = 0;
    logic   bp_on = 1'b0;

    alu_pipe_top UUT (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_rd(wb_rd),
        .wb_data(wb_data), .wb_illegal(wb_illegal)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // writeback back-pressure drops ready on about a third of the cycles
    always @(posedge clk) begin
        #1;
        if (bp_on)
            wb_ready = ({$random(seed)} % 3) != 0;
    end

    // run limit scales with the table length
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("timeout: the pipeline did not retire the table in %0d cycles",
                     timeout_limit);
            $display("Errors found");
            $fatal(1, "run timed out");
        end
    end

    task automatic compare_value(input string name, input logic [`XLEN-1:0] expected,
                                 input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // ----------------------------------------
    // instruction encoders for the base ISA formats
    // ----------------------------------------
    function automatic logic [`INSTR_W-1:0] r_type(input int f7, input int rs2,
                                                   input int rs1, input int f3,
                                                   input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OPC_OP};
    endfunction

    // imm is truncated to 12 bits
    // srai puts 0100000 in the top bits
    function automatic logic [`INSTR_W-1:0] i_type(input int imm, input int rs1,
                                                   input int f3, input int rd);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), OPC_OP_IMM};
    endfunction

    task automatic add_entry(input string name, input logic [`INSTR_W-1:0] instr,
                             input int rd, input logic [`XLEN-1:0] data, input int ill);
        names.push_back(name);
        instrs.push_back(instr);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        exp_ill.push_back(ill);
    endtask

    // ----------------------------------------
    // program and expected results
    // ----------------------------------------
    task automatic build_table();
        // each row holds name, instruction, rd, value and illegal flag
        // registers start at zero after reset
        add_entry("addi pos", i_type(100, 0, 0, 1), 1, 64'h64, 0);
        add_entry("addi neg", i_type(-5, 0, 0, 2), 2, 64'hFFFFFFFFFFFFFFFB, 0);
        add_entry("xori", i_type(15, 1, 4, 3), 3, 64'h6B, 0);
        add_entry("ori", i_type(12, 1, 6, 4), 4, 64'h6C, 0);
        add_entry("andi", i_type(44, 1, 7, 5), 5, 64'h24, 0);
        add_entry("slti", i_type(0, 2, 2, 6), 6, 64'h1, 0);
        add_entry("sltiu", i_type(5, 2, 3, 7), 7, 64'h0, 0);
        add_entry("slli", i_type(40, 1, 1, 8), 8, 64'h0000640000000000, 0);
        add_entry("srli", i_type(60, 2, 5, 9), 9, 64'hF, 0);
        add_entry("srai", i_type(1025, 2, 5, 10), 10, 64'hFFFFFFFFFFFFFFFD, 0);
        // each one leans on the one before, so decode stalls and forwards
        add_entry("add chain", r_type(0, 2, 1, 0, 11), 11, 64'h5F, 0);
        add_entry("add fwd", r_type(0, 1, 11, 0, 12), 12, 64'hC3, 0);
        add_entry("sub fwd", r_type(32, 11, 12, 0, 13), 13, 64'h64, 0);
        add_entry("xor fwd", r_type(0, 12, 13, 4, 14), 14, 64'hA7, 0);
        add_entry("or fwd", r_type(0, 3, 14, 6, 15), 15, 64'hEF, 0);
        add_entry("and fwd", r_type(0, 13, 15, 7, 16), 16, 64'h64, 0);
        // shift amount is 0x64 masked to 6 bits which is 36
        add_entry("sll fwd", r_type(0, 16, 12, 1, 17), 17, 64'h00000C3000000000, 0);
        add_entry("add two back", r_type(0, 14, 16, 0, 18), 18, 64'h10B, 0);
        // signed against unsigned
        add_entry("slt neg", r_type(0, 1, 2, 2, 19), 19, 64'h1, 0);
        add_entry("sltu neg", r_type(0, 1, 2, 3, 20), 20, 64'h0, 0);
        add_entry("addi shamt", i_type(4, 0, 0, 21), 21, 64'h4, 0);
        add_entry("slli top", i_type(56, 12, 1, 22), 22, 64'hC300000000000000, 0);
        add_entry("sra top", r_type(32, 21, 22, 5, 23), 23, 64'hFC30000000000000, 0);
        add_entry("srl top", r_type(0, 21, 22, 5, 24), 24, 64'h0C30000000000000, 0);
        add_entry("slt top", r_type(0, 1, 22, 2, 25), 25, 64'h1, 0);
        add_entry("sltu top", r_type(0, 1, 22, 3, 26), 26, 64'h0, 0);
        // neither ld x5 nor mul x6 may touch its rd
        add_entry("bad opcode", {12'd0, 5'd1, 3'd3, 5'd5, 7'b0000011}, 5, 64'h0, 1);
        add_entry("bad funct7", r_type(1, 1, 1, 0, 6), 6, 64'h0, 1);
        add_entry("x5 kept", r_type(0, 0, 5, 0, 27), 27, 64'h24, 0);
        add_entry("x6 kept", r_type(0, 0, 6, 0, 28), 28, 64'h1, 0);
        // the x0 result still retires while the register stays zero
        add_entry("write x0", i_type(55, 1, 0, 0), 0, 64'h9B, 0);
        add_entry("read x0", r_type(0, 0, 0, 0, 29), 29, 64'h0, 0);
    endtask

    // ----------------------------------------
    // driver and monitor
    // ----------------------------------------
    task automatic drive_instrs();
        logic taken;
        @(posedge clk);
        #1;
        for (int i = 0; i < instrs.size(); i++) begin
            in_valid = 1'b1;
            in_instr = instrs[i];
            taken    = 1'b0;
            // hold the word until the edge that takes it
            while (!taken) begin
                @(negedge clk);
                taken = in_ready;
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
        in_instr = '0;
    endtask

    task automatic watch_results();
        int k;
        k = 0;
        while (k < instrs.size()) begin
            @(negedge clk);
            if (wb_valid && wb_ready) begin
                compare_value({names[k], " rd"}, 64'(exp_rd[k]), 64'(wb_rd));
                compare_value({names[k], " illegal"}, 64'(exp_ill[k]), 64'(wb_illegal));
                // result value of an illegal entry is undefined
                if (exp_ill[k] == 0)
                    compare_value({names[k], " data"}, exp_data[k], wb_data);
                k++;
            end
        end
    endtask

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        build_table();
        timeout_limit = 20 * instrs.size() + 50;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // empty pipeline takes input at once
        @(negedge clk);
        compare_value("wb_valid after reset", 64'd0, 64'(wb_valid));
        compare_value("in_ready after reset", 64'd1, 64'(in_ready));
        bp_on = 1'b1;

        fork
            drive_instrs();
            watch_results();
        join

        // a duplicate would show up as another retirement
        repeat (4) begin
            @(negedge clk);
            compare_value("no extra retire", 64'd0, 64'(wb_valid));
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
core_pkg.sv
pipe_ifs.sv
reg_file.sv
instr_decode.sv
alu_execute.sv
result_writeback.sv
alu_pipe_top.sv
tb_alu_pipe.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat sim.f)) core_params.svh

run: obj_dir/Vtb_alu_pipe
	./obj_dir/Vtb_alu_pipe

# rebuilt only when a source or the file list changes
obj_dir/Vtb_alu_pipe: sim.f $(SRCS)
	verilator --binary --timescale 1ns/10ps --top-module tb_alu_pipe -f sim.f

clean:
	rm -rf obj_dir

.PHONY: run clean
